// File: rtl/boardPkg.sv
package boardPkg;

    // Contents of one board cell
    typedef enum logic [1:0] {
        WATER = 2'b00,
        SHIP  = 2'b01,
        MISS  = 2'b10,
        HIT   = 2'b11
    } cellState_t;

    localparam int BOARD_SIZE  = 5;                        // Rows and columns per board
    localparam int CELL_SIZE   = 58;                       // Interior ends below this offset
    localparam int FRAME_WIDTH = 4;                        // Frame before the interior
    localparam int CELL_PITCH  = CELL_SIZE + FRAME_WIDTH;  // One cell on screen

    localparam int DIVIDER_X      = 310;  // First divider column
    localparam int DIVIDER_WIDTH  = 2;
    localparam int ENEMY_COL_BASE = 5;    // First screen cell column of the enemy board

    localparam int COORD_W = 10;  // Pixel coordinate
    localparam int IDX_W   = 3;   // Row and column index

    // True when a coordinate lies inside the interior of its cell.
    // Applied to x and y separately by both board views.
    function automatic logic isInterior(input logic [COORD_W-1:0] coord);
        logic [COORD_W-1:0] offset;
        offset = COORD_W'(coord % CELL_PITCH);
        return (offset >= FRAME_WIDTH) && (offset < CELL_SIZE);
    endfunction

    // Cell index along one axis
    function automatic logic [COORD_W-1:0] cellIndex(input logic [COORD_W-1:0] coord);
        return COORD_W'(coord / CELL_PITCH);
    endfunction

endpackage

// File: rtl/colorPkg.sv
package colorPkg;

    localparam int CH_W = 8;  // Bits per colour channel

    // Player board palette
    localparam logic [3*CH_W-1:0] COL_BLUE   = 24'h0000FF;  // Water
    localparam logic [3*CH_W-1:0] COL_GREEN  = 24'h00FF00;  // Ship
    localparam logic [3*CH_W-1:0] COL_RED    = 24'hFF0000;  // Miss
    localparam logic [3*CH_W-1:0] COL_YELLOW = 24'hFFFF00;  // Hit, also enemy miss

    // Enemy board palette
    localparam logic [3*CH_W-1:0] COL_GREY   = 24'h202020;  // Water
    localparam logic [3*CH_W-1:0] COL_PURPLE = 24'h800080;  // Ship
    localparam logic [3*CH_W-1:0] COL_ORANGE = 24'hFFA500;  // Hit

    // Placement cursor
    localparam logic [3*CH_W-1:0] COL_PLACE_DONE = 24'hFF8C00;  // Confirmed span
    localparam logic [3*CH_W-1:0] COL_PLACE_SEL  = 24'h8B4513;  // Span being chosen

    // Background, divider and blanking
    localparam logic [3*CH_W-1:0] COL_WHITE = 24'hFFFFFF;
    localparam logic [3*CH_W-1:0] COL_BLACK = 24'h000000;

endpackage

// File: rtl/vgaTiming.sv
`timescale 1ns/1ps

module vgaTiming import boardPkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic               clk,
    input  logic               reset,
    output logic [COORD_W-1:0] pixelX,
    output logic [COORD_W-1:0] pixelY,
    output logic               active,
    output logic               hsyncRaw,
    output logic               vsyncRaw
);

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    logic [COORD_W-1:0] hCount;
    logic [COORD_W-1:0] vCount;
    logic               lineEnd;
    logic               frameEnd;

    always_comb begin
        lineEnd  = (hCount == COORD_W'(H_TOTAL - 1));
        frameEnd = (vCount == COORD_W'(V_TOTAL - 1));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hCount <= '0;
            vCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;
            if (frameEnd) begin
                vCount <= '0;  // Wrap to the top of the next frame
            end else begin
                vCount <= vCount + 1'b1;
            end
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    always_comb begin
        pixelX   = hCount;
        pixelY   = vCount;
        active   = (hCount < H_ACTIVE) && (vCount < V_ACTIVE);
        // Sync pulses are active low
        hsyncRaw = !((hCount >= H_SYNC_START) && (hCount < H_SYNC_START + H_SYNC));
        vsyncRaw = !((vCount >= V_SYNC_START) && (vCount < V_SYNC_START + V_SYNC));
    end

    // Views index their cells from pixelX only inside the visible area
    activeInRange: assert property (@(posedge clk) disable iff (reset)
        active |-> (pixelX < H_ACTIVE));

endmodule

// File: rtl/playerBoardView.sv
`timescale 1ns/1ps

module playerBoardView import boardPkg::*; import colorPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [COORD_W-1:0] pixelX,
    input  logic [COORD_W-1:0] pixelY,
    input  logic               playerWrite,
    input  logic [IDX_W-1:0]   writeRow,
    input  logic [IDX_W-1:0]   writeCol,
    input  cellState_t         writeState,
    input  logic [IDX_W-1:0]   cursorRow,
    input  logic [IDX_W-1:0]   cursorCol,
    input  logic [IDX_W-1:0]   shipLength,
    input  logic               confirmPlacement,
    output logic               inCell,
    output logic [3*CH_W-1:0]  cellColor
);

    cellState_t cells [BOARD_SIZE][BOARD_SIZE];  // Indexed [row][col]

    logic [COORD_W-1:0] colIdx;
    logic [COORD_W-1:0] rowIdx;
    logic [COORD_W-1:0] spanEnd;
    logic               hit;
    logic               inSpan;
    cellState_t         state;
    logic [3*CH_W-1:0]  colorNext;

    // Board storage, one cell per write strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BOARD_SIZE; i++) begin
                for (int j = 0; j < BOARD_SIZE; j++) begin
                    cells[i][j] <= WATER;
                end
            end
        end else if (playerWrite) begin
            cells[writeRow][writeCol] <= writeState;
        end
    end

    always_comb begin
        colIdx  = cellIndex(pixelX);
        rowIdx  = cellIndex(pixelY);
        hit     = (colIdx < BOARD_SIZE) && (rowIdx < BOARD_SIZE)
                  && isInterior(pixelX) && isInterior(pixelY);
        spanEnd = COORD_W'(cursorCol) + COORD_W'(shipLength);  // One past the last ship cell
        inSpan  = (rowIdx == COORD_W'(cursorRow))
                  && (colIdx >= COORD_W'(cursorCol)) && (colIdx < spanEnd);
        if (hit) begin
            state = cells[rowIdx[IDX_W-1:0]][colIdx[IDX_W-1:0]];
        end else begin
            state = WATER;
        end
    end

    // Cursor overlay wins over the stored state
    always_comb begin
        if (inSpan) begin
            colorNext = confirmPlacement ? COL_PLACE_DONE : COL_PLACE_SEL;
        end else begin
            case (state)
                WATER: colorNext = COL_BLUE;
                SHIP:  colorNext = COL_GREEN;
                MISS:  colorNext = COL_RED;
                HIT:   colorNext = COL_YELLOW;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inCell <= 1'b0;
        end else begin
            inCell <= hit;
        end
        cellColor <= colorNext;  // Only used while inCell is high
    end

    playerWriteInRange: assert property (@(posedge clk) disable iff (reset)
        playerWrite |-> (writeRow < BOARD_SIZE) && (writeCol < BOARD_SIZE));

endmodule

// File: rtl/enemyBoardView.sv
`timescale 1ns/1ps

module enemyBoardView import boardPkg::*; import colorPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [COORD_W-1:0] pixelX,
    input  logic [COORD_W-1:0] pixelY,
    input  logic               enemyWrite,
    input  logic [IDX_W-1:0]   writeRow,
    input  logic [IDX_W-1:0]   writeCol,
    input  cellState_t         writeState,
    output logic               inCell,
    output logic [3*CH_W-1:0]  cellColor
);

    cellState_t cells [BOARD_SIZE][BOARD_SIZE];

    logic [COORD_W-1:0] colIdx;
    logic [COORD_W-1:0] rowIdx;
    logic [COORD_W-1:0] boardCol;
    logic               hit;
    cellState_t         state;
    logic [3*CH_W-1:0]  colorNext;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BOARD_SIZE; i++) begin
                for (int j = 0; j < BOARD_SIZE; j++) begin
                    cells[i][j] <= WATER;
                end
            end
        end else if (enemyWrite) begin
            cells[writeRow][writeCol] <= writeState;
        end
    end

    always_comb begin
        colIdx   = cellIndex(pixelX);
        rowIdx   = cellIndex(pixelY);
        boardCol = colIdx - COORD_W'(ENEMY_COL_BASE);  // Screen column to board column
        hit      = (colIdx >= ENEMY_COL_BASE) && (colIdx < ENEMY_COL_BASE + BOARD_SIZE)
                   && (rowIdx < BOARD_SIZE) && isInterior(pixelX) && isInterior(pixelY);
        if (hit) begin
            state = cells[rowIdx[IDX_W-1:0]][boardCol[IDX_W-1:0]];
        end else begin
            state = WATER;
        end
        case (state)
            WATER: colorNext = COL_GREY;
            SHIP:  colorNext = COL_PURPLE;
            MISS:  colorNext = COL_YELLOW;
            HIT:   colorNext = COL_ORANGE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inCell <= 1'b0;
        end else begin
            inCell <= hit;
        end
        cellColor <= colorNext;
    end

    enemyWriteInRange: assert property (@(posedge clk) disable iff (reset)
        enemyWrite |-> (writeRow < BOARD_SIZE) && (writeCol < BOARD_SIZE));

endmodule

// File: rtl/pixelCompositor.sv
`timescale 1ns/1ps

module pixelCompositor import boardPkg::*; import colorPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [COORD_W-1:0] pixelX,
    input  logic               active,
    input  logic               hsyncRaw,
    input  logic               vsyncRaw,
    input  logic               playerInCell,
    input  logic [3*CH_W-1:0]  playerColor,
    input  logic               enemyInCell,
    input  logic [3*CH_W-1:0]  enemyColor,
    output logic [CH_W-1:0]    r,
    output logic [CH_W-1:0]    g,
    output logic [CH_W-1:0]    b,
    output logic               hsync,
    output logic               vsync,
    output logic               de
);

    // Stage matching the view registers
    logic [COORD_W-1:0] pixelXD;
    logic               activeD;
    logic               hsyncD;
    logic               vsyncD;
    logic               onDivider;
    logic [3*CH_W-1:0]  pixelColor;

    always_ff @(posedge clk) begin
        if (reset) begin
            activeD <= 1'b0;
            hsyncD  <= 1'b1;  // Idle high
            vsyncD  <= 1'b1;
        end else begin
            activeD <= active;
            hsyncD  <= hsyncRaw;
            vsyncD  <= vsyncRaw;
        end
        pixelXD <= pixelX;
    end

    always_comb begin
        onDivider = (pixelXD >= DIVIDER_X) && (pixelXD < DIVIDER_X + DIVIDER_WIDTH);
        if (!activeD || onDivider) begin
            pixelColor = COL_BLACK;
        end else if (playerInCell) begin
            pixelColor = playerColor;
        end else if (enemyInCell) begin
            pixelColor = enemyColor;
        end else begin
            pixelColor = COL_WHITE;  // Background and cell frames
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            {r, g, b} <= '0;
            hsync     <= 1'b1;
            vsync     <= 1'b1;
            de        <= 1'b0;
        end else begin
            {r, g, b} <= pixelColor;
            hsync     <= hsyncD;
            vsync     <= vsyncD;
            de        <= activeD;
        end
    end

    // The two boards sit in disjoint screen columns
    boardsDisjoint: assert property (@(posedge clk) disable iff (reset)
        !(playerInCell && enemyInCell));

endmodule

// File: rtl/battleshipDisplay.sv
`timescale 1ns/1ps

module battleshipDisplay import boardPkg::*; import colorPkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             playerWrite,
    input  logic             enemyWrite,
    input  logic [IDX_W-1:0] writeRow,
    input  logic [IDX_W-1:0] writeCol,
    input  cellState_t       writeState,
    input  logic [IDX_W-1:0] cursorRow,
    input  logic [IDX_W-1:0] cursorCol,
    input  logic [IDX_W-1:0] shipLength,
    input  logic             confirmPlacement,
    output logic [CH_W-1:0]  r,
    output logic [CH_W-1:0]  g,
    output logic [CH_W-1:0]  b,
    output logic             hsync,
    output logic             vsync,
    output logic             de
);

    logic [COORD_W-1:0] pixelX;
    logic [COORD_W-1:0] pixelY;
    logic               active;
    logic               hsyncRaw;
    logic               vsyncRaw;
    logic               playerInCell;
    logic [3*CH_W-1:0]  playerColor;
    logic               enemyInCell;
    logic [3*CH_W-1:0]  enemyColor;

    vgaTiming #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) timing (
        .clk(clk), .reset(reset), .pixelX(pixelX), .pixelY(pixelY),
        .active(active), .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw)
    );

    playerBoardView playerView (
        .clk(clk), .reset(reset), .pixelX(pixelX), .pixelY(pixelY),
        .playerWrite(playerWrite), .writeRow(writeRow), .writeCol(writeCol),
        .writeState(writeState), .cursorRow(cursorRow), .cursorCol(cursorCol),
        .shipLength(shipLength), .confirmPlacement(confirmPlacement),
        .inCell(playerInCell), .cellColor(playerColor)
    );

    enemyBoardView enemyView (
        .clk(clk), .reset(reset), .pixelX(pixelX), .pixelY(pixelY),
        .enemyWrite(enemyWrite), .writeRow(writeRow), .writeCol(writeCol),
        .writeState(writeState), .inCell(enemyInCell), .cellColor(enemyColor)
    );

    pixelCompositor compositor (
        .clk(clk), .reset(reset), .pixelX(pixelX), .active(active),
        .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw),
        .playerInCell(playerInCell), .playerColor(playerColor),
        .enemyInCell(enemyInCell), .enemyColor(enemyColor),
        .r(r), .g(g), .b(b), .hsync(hsync), .vsync(vsync), .de(de)
    );

endmodule

// File: verif/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: verif/tbBattleshipDisplay.sv
`timescale 1ns/1ps

module tbBattleshipDisplay import boardPkg::*; import colorPkg::*; ();

    localparam int H_ACT        = 640;
    localparam int V_ACT        = 480;
    localparam int H_TOTAL      = 800;
    localparam int FRAME_CYCLES = 800 * 525;
    localparam int CENTRE       = CELL_PITCH / 2;  // Offset of a cell centre

    logic clk;
    logic reset;
    logic playerWrite;
    logic enemyWrite;
    logic [IDX_W-1:0] writeRow;
    logic [IDX_W-1:0] writeCol;
    cellState_t writeState;
    logic [IDX_W-1:0] cursorRow;
    logic [IDX_W-1:0] cursorCol;
    logic [IDX_W-1:0] shipLength;
    logic confirmPlacement;
    logic [CH_W-1:0] r;
    logic [CH_W-1:0] g;
    logic [CH_W-1:0] b;
    logic hsync;
    logic vsync;
    logic de;

    logic [3*CH_W-1:0] frameBuf [H_ACT*V_ACT];  // One captured frame
    int lineWidth [V_ACT];
    int linesSeen;
    int blankNonBlack;
    int deInWait;
    cellState_t playerModel [BOARD_SIZE][BOARD_SIZE];
    cellState_t enemyModel [BOARD_SIZE][BOARD_SIZE];
    int curRow;
    int curCol;
    int curLen;
    logic curConfirm;
    int checks;
    int valueErrors;
    int timeouts;

    clockGen clocks (.clk(clk), .reset(reset));

    battleshipDisplay #(
        .H_ACTIVE(H_ACT), .H_FRONT(16), .H_SYNC(96), .H_BACK(48),
        .V_ACTIVE(V_ACT), .V_FRONT(10), .V_SYNC(2), .V_BACK(33)
    ) uut (
        .clk(clk), .reset(reset), .playerWrite(playerWrite), .enemyWrite(enemyWrite),
        .writeRow(writeRow), .writeCol(writeCol), .writeState(writeState),
        .cursorRow(cursorRow), .cursorCol(cursorCol), .shipLength(shipLength),
        .confirmPlacement(confirmPlacement),
        .r(r), .g(g), .b(b), .hsync(hsync), .vsync(vsync), .de(de)
    );

    function automatic logic [3*CH_W-1:0] playerPalette(input cellState_t st);
        case (st)
            WATER:   return COL_BLUE;
            SHIP:    return COL_GREEN;
            MISS:    return COL_RED;
            default: return COL_YELLOW;
        endcase
    endfunction

    function automatic logic [3*CH_W-1:0] enemyPalette(input cellState_t st);
        case (st)
            WATER:   return COL_GREY;
            SHIP:    return COL_PURPLE;
            MISS:    return COL_YELLOW;
            default: return COL_ORANGE;
        endcase
    endfunction

    // Reference colour of a visible pixel from the boards written so far
    function automatic logic [3*CH_W-1:0] expectedPixel(input int x, input int y);
        int col;
        int row;
        bit interior;
        col = x / CELL_PITCH;
        row = y / CELL_PITCH;
        interior = (x - col * CELL_PITCH >= FRAME_WIDTH) && (x - col * CELL_PITCH < CELL_SIZE)
                   && (y - row * CELL_PITCH >= FRAME_WIDTH) && (y - row * CELL_PITCH < CELL_SIZE);
        if (x >= DIVIDER_X && x < DIVIDER_X + DIVIDER_WIDTH) begin
            return COL_BLACK;
        end
        if (!interior || row >= BOARD_SIZE || col >= ENEMY_COL_BASE + BOARD_SIZE) begin
            return COL_WHITE;
        end
        if (col >= ENEMY_COL_BASE) begin
            return enemyPalette(enemyModel[row][col - ENEMY_COL_BASE]);
        end
        if (row == curRow && col >= curCol && col < curCol + curLen) begin
            return curConfirm ? COL_PLACE_DONE : COL_PLACE_SEL;  // Cursor span
        end
        return playerPalette(playerModel[row][col]);
    endfunction

    task automatic timeoutHit(input string what);
        $display("Timeout: gave up waiting for %s", what);
        timeouts++;
    endtask

    task automatic checkValue(input string testName, input string what,
                              input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            $display("ERR %s %s: expected %0d, actual %0d", testName, what, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkColor(input string testName, input int x, input int y,
                              input logic [3*CH_W-1:0] expected);
        logic [3*CH_W-1:0] actual;
        actual = frameBuf[y*H_ACT + x];
        checks++;
        if (actual !== expected) begin
            $display("ERR %s pixel (%0d,%0d): expected %06h, actual %06h",
                     testName, x, y, expected, actual);
            valueErrors++;
        end
    endtask

    // Centres of all cells on both boards against the reference
    task automatic checkBoards(input string testName);
        for (int row = 0; row < BOARD_SIZE; row++) begin
            for (int col = 0; col < 2 * BOARD_SIZE; col++) begin
                checkColor(testName, col * CELL_PITCH + CENTRE, row * CELL_PITCH + CENTRE,
                           expectedPixel(col * CELL_PITCH + CENTRE, row * CELL_PITCH + CENTRE));
            end
        end
    endtask

    task automatic waitFall(input bit vertical);
        int guard;
        logic prev;
        logic level;
        bit fell;
        guard = 0;
        prev = 1'b0;
        fell = 0;
        deInWait = 0;
        while (!fell && guard < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            guard++;
            level = vertical ? vsync : hsync;
            fell = prev && !level;
            prev = level;
            if (de) begin
                deInWait++;
            end
        end
        if (!fell) begin
            timeoutHit(vertical ? "a vsync falling edge" : "an hsync falling edge");
        end
    endtask

    task automatic lowWidth(input bit vertical, output int width);
        int guard;
        waitFall(vertical);
        guard = 0;
        width = 0;
        while ((vertical ? vsync : hsync) == 1'b0 && guard < FRAME_CYCLES) begin
            width++;
            @(negedge clk);
            guard++;
        end
        if (guard >= FRAME_CYCLES) begin
            timeoutHit("the end of a sync pulse");
        end
    endtask

    // Stores every de pixel of the next frame, x and y follow the de count
    task automatic captureFrame();
        int x;
        int guard;
        logic deLast;
        waitFall(1'b1);
        x = 0;
        linesSeen = 0;
        blankNonBlack = 0;
        guard = 0;
        deLast = 1'b0;
        while (linesSeen < V_ACT && guard < FRAME_CYCLES) begin
            @(negedge clk);
            guard++;
            if (de) begin
                if (x < H_ACT) begin
                    frameBuf[linesSeen*H_ACT + x] = {r, g, b};
                end
                x++;
            end else begin
                if ({r, g, b} !== '0) begin
                    blankNonBlack++;
                end
                if (deLast) begin
                    lineWidth[linesSeen] = x;
                    linesSeen++;
                    x = 0;
                end
            end
            deLast = de;
        end
        if (linesSeen < V_ACT) begin
            timeoutHit("the last active line of a frame");
        end
    endtask

    task automatic writeCell(input bit toEnemy, input int row, input int col,
                             input cellState_t st);
        @(posedge clk);
        playerWrite <= !toEnemy;
        enemyWrite  <= toEnemy;
        writeRow    <= IDX_W'(row);
        writeCol    <= IDX_W'(col);
        writeState  <= st;
        @(posedge clk);
        playerWrite <= 1'b0;
        enemyWrite  <= 1'b0;
        if (toEnemy) begin
            enemyModel[row][col] = st;
        end else begin
            playerModel[row][col] = st;
        end
    endtask

    task automatic setCursor(input int row, input int col, input int len, input logic confirm);
        @(posedge clk);
        cursorRow        <= IDX_W'(row);
        cursorCol        <= IDX_W'(col);
        shipLength       <= IDX_W'(len);
        confirmPlacement <= confirm;
        curRow = row;
        curCol = col;
        curLen = len;
        curConfirm = confirm;
    endtask

    task automatic resetState();
        int guard;
        int cyclesAfter;
        guard = 0;
        cyclesAfter = 0;
        @(posedge clk);  // First edge loads the reset values
        do begin  // Last pass follows the first edge without reset
            @(negedge clk);
            guard++;
            if (!reset) begin
                cyclesAfter++;
            end
            checks++;
            if (hsync !== 1'b1 || vsync !== 1'b1 || de !== 1'b0 || {r, g, b} !== '0) begin
                $display("ERR resetState: expected hsync 1 vsync 1 de 0 rgb 000000, %s",
                         $sformatf("actual hsync %b vsync %b de %b rgb %06h",
                                   hsync, vsync, de, {r, g, b}));
                valueErrors++;
            end
        end while (cyclesAfter < 2 && guard < 20);
        if (cyclesAfter < 2) begin
            timeoutHit("reset release");
        end
    endtask

    task automatic syncTiming();
        int width;
        captureFrame();
        checkValue("syncTiming", "lines with de", V_ACT, linesSeen);
        for (int y = 0; y < linesSeen; y++) begin
            checkValue("syncTiming", $sformatf("de cycles on line %0d", y), H_ACT, lineWidth[y]);
        end
        checkValue("syncTiming", "non-black blanking cycles", 0, blankNonBlack);
        lowWidth(1'b1, width);
        checkValue("syncTiming", "de cycles after the last line", 0, deInWait);
        checkValue("syncTiming", "vsync low cycles", 2 * H_TOTAL, width);
        lowWidth(1'b0, width);
        checkValue("syncTiming", "hsync low cycles", 96, width);
    endtask

    task automatic emptyBoards();
        captureFrame();
        for (int row = 0; row < BOARD_SIZE; row++) begin
            for (int col = 0; col < BOARD_SIZE; col++) begin
                checkColor("emptyBoards", col * CELL_PITCH + CENTRE,
                           row * CELL_PITCH + CENTRE, COL_BLUE);
                checkColor("emptyBoards", (col + ENEMY_COL_BASE) * CELL_PITCH + CENTRE,
                           row * CELL_PITCH + CENTRE, COL_GREY);
            end
        end
        checkColor("emptyBoards", CELL_PITCH + 1, CENTRE, COL_WHITE);      // Frame, left edge
        checkColor("emptyBoards", CENTRE, CELL_PITCH - 2, COL_WHITE);      // Frame, bottom edge
        checkColor("emptyBoards", 7 * CELL_PITCH + 59, 100, COL_WHITE);    // Enemy frame
        checkColor("emptyBoards", DIVIDER_X, 100, COL_BLACK);
        checkColor("emptyBoards", DIVIDER_X + 1, 400, COL_BLACK);
        checkColor("emptyBoards", 100, 400, COL_WHITE);  // Below the boards
        checkColor("emptyBoards", 500, V_ACT - 1, COL_WHITE);
        checkColor("emptyBoards", 630, CENTRE, COL_WHITE);
    endtask

    task automatic playerCells();
        writeCell(1'b0, 0, 0, SHIP);
        writeCell(1'b0, 1, 2, MISS);
        writeCell(1'b0, 4, 4, HIT);
        writeCell(1'b0, 2, 3, SHIP);
        writeCell(1'b0, 2, 3, WATER);  // Overwritten back
        captureFrame();
        checkBoards("playerCells");
        // Interior corners and the first frame pixel of cell 0,0
        checkColor("playerCells", FRAME_WIDTH, FRAME_WIDTH, COL_GREEN);
        checkColor("playerCells", CELL_SIZE - 1, CELL_SIZE - 1, COL_GREEN);
        checkColor("playerCells", CELL_SIZE, FRAME_WIDTH, COL_WHITE);
        checkColor("playerCells", FRAME_WIDTH - 1, CENTRE, COL_WHITE);
    endtask

    task automatic enemyRandom();
        for (int row = 0; row < BOARD_SIZE; row++) begin
            for (int col = 0; col < BOARD_SIZE; col++) begin
                writeCell(1'b1, row, col, cellState_t'(2'($urandom % 4)));
            end
        end
        captureFrame();
        checkBoards("enemyRandom");
    endtask

    task automatic placementOverlay();
        writeCell(1'b0, 2, 1, SHIP);
        writeCell(1'b0, 2, 3, HIT);  // Hidden under the span
        setCursor(2, 2, 3, 1'b0);
        captureFrame();
        checkBoards("placementOverlay");
        checkColor("placementOverlay", 4 * CELL_PITCH + CENTRE, 2 * CELL_PITCH + CENTRE,
                   COL_PLACE_SEL);
        setCursor(2, 2, 3, 1'b1);
        captureFrame();
        checkBoards("placementOverlay");
        checkColor("placementOverlay", 2 * CELL_PITCH + CENTRE, 2 * CELL_PITCH + CENTRE,
                   COL_PLACE_DONE);
    endtask

    initial begin
        void'($urandom(77552));
        playerWrite      = 1'b0;
        enemyWrite       = 1'b0;
        writeRow         = '0;
        writeCol         = '0;
        writeState       = WATER;
        cursorRow        = '0;
        cursorCol        = '0;
        shipLength       = '0;  // No span shown
        confirmPlacement = 1'b0;
        curRow = 0;
        curCol = 0;
        curLen = 0;
        curConfirm = 1'b0;
        checks = 0;
        valueErrors = 0;
        timeouts = 0;
        for (int row = 0; row < BOARD_SIZE; row++) begin
            for (int col = 0; col < BOARD_SIZE; col++) begin
                playerModel[row][col] = WATER;
                enemyModel[row][col] = WATER;
            end
        end

        resetState();
        syncTiming();
        emptyBoards();
        playerCells();
        enemyRandom();
        placementOverlay();

        $display("Checks %0d, value errors %0d, timeouts %0d", checks, valueErrors, timeouts);
        if (valueErrors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
rtl/boardPkg.sv
rtl/colorPkg.sv
rtl/vgaTiming.sv
rtl/playerBoardView.sv
rtl/enemyBoardView.sv
rtl/pixelCompositor.sv
rtl/battleshipDisplay.sv
verif/clockGen.sv
verif/tbBattleshipDisplay.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass message
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbBattleshipDisplay -f sim.f -o simBattleship

output=$(./obj_dir/simBattleship)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
